// File: compile.f
+incdir+.
dotmatrix_pkg.sv
countdown_ctrl.sv
row_scanner.sv
glyph_rom.sv
matrix_top.sv
tb_matrix_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the dot-matrix testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_matrix_top -f compile.f -o sim_matrix

./obj_dir/sim_matrix | tee sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi

// File: tb_matrix_top.sv
`timescale 1ns/1ps
`include "dotmatrix_params.svh"

module tb_matrix_top;

    localparam int CLK_PERIOD = 10;
    localparam int BUSY_LEN   = `DM_COUNT_START * `DM_HOLD_CYCLES;
    localparam int GAP_LIMIT  = 66;
    localparam int WATCHDOG   = (4 * BUSY_LEN + 3 * GAP_LIMIT + 50) * CLK_PERIOD;

    logic clk;
    logic rst;
    logic start;
    logic busy;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;

    logic [31:0] lfsr;
    logic [7:0]  prev_row;
    int          run_len;
    logic        prev_busy;
    int          busy_len;
    logic [1:0]  phase_now;
    logic [1:0]  last_phase;
    logic [3:1]  seen;

    matrix_top i_matrix_top (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .busy  (busy),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped after a failure.");
    endtask

    task automatic check_failed(input string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        stop_with_failure();
    endtask

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // 0 dark, 1 red, 2 yellow, 3 green.
    function automatic logic [1:0] color_phase(input logic [7:0] r, input logic [7:0] g);
        if (r == 8'd0 && g == 8'd0)
            return 2'd0;
        if (g == 8'd0)
            return 2'd1;
        if (r == g)
            return 2'd2;
        if (r == 8'd0)
            return 2'd3;
        return 2'd0;
    endfunction

    assign phase_now = color_phase(colr, colg);

    // Row run length, busy length and colour phases seen.
    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            prev_row   <= '0;
            run_len    <= 0;
            prev_busy  <= 1'b0;
            busy_len   <= 0;
            last_phase <= '0;
            seen       <= '0;
        end
        else
        begin
            prev_row  <= row;
            run_len   <= (row == prev_row) ? run_len + 1 : 1;
            prev_busy <= busy;
            busy_len  <= busy ? busy_len + 1 : 0;
            if (busy && !prev_busy)
            begin
                last_phase <= '0;
                seen       <= '0;
            end
            else if (phase_now != 2'd0)
            begin
                last_phase       <= phase_now;
                seen[phase_now]  <= 1'b1;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk)
        $fell(rst) |-> (!busy && row == 8'd0 && colr == 8'd0 && colg == 8'd0))
        else check_failed("outputs not zero right after reset");

    a_start_busy: assert property (@(posedge clk) disable iff (rst)
        (start && !busy) |=> busy)
        else check_failed("busy did not rise after start");

    a_row_onehot: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> $onehot(row))
        else check_failed($sformatf("row select %b is not one-hot", row));

    a_row_order: assert property (@(posedge clk) disable iff (rst)
        (prev_row != 8'd0 && row != prev_row) |->
            (row == {prev_row[6:0], prev_row[7]} && run_len == `DM_SCAN_CYCLES))
        else check_failed($sformatf("row %b after %b held %0d cycles", row, prev_row, run_len));

    a_row_length: assert property (@(posedge clk) disable iff (rst)
        run_len <= `DM_SCAN_CYCLES)
        else check_failed($sformatf("row held for %0d cycles", run_len));

    a_color_rule: assert property (@(posedge clk) disable iff (rst)
        (colg == 8'd0 || colr == 8'd0 || colr == colg))
        else check_failed($sformatf("mixed colours red %b green %b", colr, colg));

    a_row0_dark: assert property (@(posedge clk) disable iff (rst)
        row[0] |-> (colr == 8'd0 && colg == 8'd0))
        else check_failed("row 0 is lit");

    a_idle_dark: assert property (@(posedge clk) disable iff (rst)
        (!busy && !$past(busy)) |-> (colr == 8'd0 && colg == 8'd0))
        else check_failed("display lit while not busy");

    a_phase_order: assert property (@(posedge clk) disable iff (rst)
        (phase_now != 2'd0) |-> (phase_now >= last_phase))
        else check_failed($sformatf("colour phase %0d after %0d", phase_now, last_phase));

    a_all_phases: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |=> (seen == 3'b111))
        else check_failed($sformatf("colour phases seen %b", seen));

    a_busy_length: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> (busy_len == BUSY_LEN))
        else check_failed($sformatf("busy lasted %0d cycles", busy_len));

    a_busy_limit: assert property (@(posedge clk) disable iff (rst)
        busy |-> (busy_len < BUSY_LEN))
        else check_failed("busy period too long");

    initial
    begin
        #(WATCHDOG);
        $display("Timeout: the countdowns did not finish in time.");
        stop_with_failure();
    end

    initial
    begin
        int gap;
        int offset;

        clk            = 1'b0;
        rst            = 1'b1;
        start          = 1'b0;
        lfsr           = 32'h338d_8bda;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < 3; n++)
        begin
            random_bits(6, gap);
            repeat (gap + 2) @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            // Second countdown also gets a start while busy.
            if (n == 1)
            begin
                random_bits(7, offset);
                repeat (offset + 20) @(negedge clk);
                start = 1'b1;
                @(negedge clk);
                start = 1'b0;
            end
            while (busy)
                @(negedge clk);
        end
        repeat (4) @(negedge clk);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: matrix_top.sv
`timescale 1ns/1ps

module matrix_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    output logic                     busy,
    output dotmatrix_pkg::row_bits_t row,
    output dotmatrix_pkg::row_bits_t colr,
    output dotmatrix_pkg::row_bits_t colg
);

    dotmatrix_pkg::digit_t   digit;
    dotmatrix_pkg::row_idx_t row_idx;

    // Digit sequence from the start pulse.
    countdown_ctrl i_countdown_ctrl (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .digit (digit),
        .busy  (busy)
    );

    // Free-running row scan.
    row_scanner i_row_scanner (
        .clk     (clk),
        .rst     (rst),
        .row_idx (row_idx)
    );

    glyph_rom i_glyph_rom (
        .clk     (clk),
        .rst     (rst),
        .digit   (digit),
        .row_idx (row_idx),
        .row     (row),
        .colr    (colr),
        .colg    (colg)
    );

endmodule

// File: glyph_rom.sv
`timescale 1ns/1ps

module glyph_rom (
    input  logic                     clk,
    input  logic                     rst,
    input  dotmatrix_pkg::digit_t    digit,
    input  dotmatrix_pkg::row_idx_t  row_idx,
    output dotmatrix_pkg::row_bits_t row,
    output dotmatrix_pkg::row_bits_t colr,
    output dotmatrix_pkg::row_bits_t colg
);

    dotmatrix_pkg::row_bits_t pat;
    logic                     red_en;
    logic                     green_en;

    // Glyph bitmaps, row 0 left dark for every digit.
    always_comb
    begin
        pat = '0;
        case (digit)
            3'd5:
            begin
                case (row_idx)
                    3'd1: pat = 8'b0111_1110;
                    3'd2: pat = 8'b0110_0000;
                    3'd3: pat = 8'b0111_1100;
                    3'd4: pat = 8'b0000_0110;
                    3'd5: pat = 8'b0000_0110;
                    3'd6: pat = 8'b0110_0110;
                    3'd7: pat = 8'b0011_1100;
                    default: pat = '0;
                endcase
            end
            3'd4:
            begin
                case (row_idx)
                    3'd1: pat = 8'b0000_1100;
                    3'd2: pat = 8'b0001_1100;
                    3'd3: pat = 8'b0010_1100;
                    3'd4: pat = 8'b0100_1100;
                    3'd5: pat = 8'b0111_1110;
                    3'd6: pat = 8'b0000_1100;
                    3'd7: pat = 8'b0000_1100;
                    default: pat = '0;
                endcase
            end
            3'd3:
            begin
                case (row_idx)
                    3'd1: pat = 8'b0011_1100;
                    3'd2: pat = 8'b0110_0110;
                    3'd3: pat = 8'b0000_0110;
                    3'd4: pat = 8'b0001_1100;
                    3'd5: pat = 8'b0000_0110;
                    3'd6: pat = 8'b0110_0110;
                    3'd7: pat = 8'b0011_1100;
                    default: pat = '0;
                endcase
            end
            3'd2:
            begin
                case (row_idx)
                    3'd1: pat = 8'b0011_1100;
                    3'd2: pat = 8'b0110_0110;
                    3'd3: pat = 8'b0000_0110;
                    3'd4: pat = 8'b0000_1100;
                    3'd5: pat = 8'b0011_0000;
                    3'd6: pat = 8'b0110_0000;
                    3'd7: pat = 8'b0111_1110;
                    default: pat = '0;
                endcase
            end
            3'd1:
            begin
                case (row_idx)
                    3'd1: pat = 8'b0001_1000;
                    3'd2: pat = 8'b0011_1000;
                    3'd7: pat = 8'b0111_1110;
                    3'd0: pat = '0;
                    default: pat = 8'b0001_1000;
                endcase
            end
            default:
            begin
                pat = '0;
            end
        endcase
    end

    // Red for 5..2, green for 3..1, both gives yellow.
    assign red_en   = (digit >= 3'd2) && (digit <= 3'd5);
    assign green_en = (digit >= 3'd1) && (digit <= 3'd3);

    // Row select and columns leave in the same cycle.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '0;
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= dotmatrix_pkg::row_bits_t'(1) << row_idx;
            colr <= red_en ? pat : '0;
            colg <= green_en ? pat : '0;
        end
    end

    a_row_onehot: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> $onehot(row))
        else $error("glyph_rom: row select %b not one-hot", row);

    a_red_only: assert property (@(posedge clk) disable iff (rst)
        ($past(digit) inside {3'd4, 3'd5}) |-> (colg == '0))
        else $error("glyph_rom: green lit for digit %0d", $past(digit));

    a_yellow: assert property (@(posedge clk) disable iff (rst)
        ($past(digit) inside {3'd2, 3'd3}) |-> (colg == colr))
        else $error("glyph_rom: red and green differ for digit %0d", $past(digit));

    a_green_or_dark: assert property (@(posedge clk) disable iff (rst)
        ($past(digit) <= 3'd1 || $past(row_idx) == 3'd0) |->
            (colr == '0 &&
             (colg == '0 || ($past(digit) == 3'd1 && $past(row_idx) != 3'd0))))
        else $error("glyph_rom: unexpected red for digit %0d", $past(digit));

endmodule

// File: row_scanner.sv
`timescale 1ns/1ps
`include "dotmatrix_params.svh"

module row_scanner (
    input  logic                    clk,
    input  logic                    rst,
    output dotmatrix_pkg::row_idx_t row_idx
);

    localparam int SCAN_W = $clog2(`DM_SCAN_CYCLES + 1);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(`DM_SCAN_CYCLES - 1);

    logic [SCAN_W-1:0] pre_cnt;
    logic              step;

    // One step per scan period.
    assign step = (pre_cnt == SCAN_LAST);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pre_cnt <= '0;
        end
        else if (step)
        begin
            pre_cnt <= '0;
        end
        else
        begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // Row index wraps 7 -> 0 by its width.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= '0;
        end
        else if (step)
        begin
            row_idx <= row_idx + 3'd1;
        end
    end

    a_row_on_step: assert property (@(posedge clk) disable iff (rst)
        !$past(step) |-> $stable(row_idx))
        else $error("row_scanner: row index moved without a step");

endmodule

// File: countdown_ctrl.sv
`timescale 1ns/1ps
`include "dotmatrix_params.svh"

module countdown_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    output dotmatrix_pkg::digit_t digit,
    output logic                  busy
);

    localparam int HOLD_W = $clog2(`DM_HOLD_CYCLES + 1);
    localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`DM_HOLD_CYCLES - 1);

    dotmatrix_pkg::countdown_state_t state;
    logic [HOLD_W-1:0]               hold_cnt;
    logic                            hold_done;

    assign hold_done = (hold_cnt == HOLD_LAST);
    assign busy      = (state == dotmatrix_pkg::CD_COUNT);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= dotmatrix_pkg::CD_IDLE;
            digit    <= '0;
            hold_cnt <= '0;
        end
        else
        begin
            case (state)
                dotmatrix_pkg::CD_IDLE:
                begin
                    // Start is only looked at while idle.
                    if (start)
                    begin
                        state    <= dotmatrix_pkg::CD_COUNT;
                        digit    <= dotmatrix_pkg::digit_t'(`DM_COUNT_START);
                        hold_cnt <= '0;
                    end
                end
                dotmatrix_pkg::CD_COUNT:
                begin
                    if (hold_done)
                    begin
                        hold_cnt <= '0;
                        digit    <= digit - 3'd1;
                        // Digit 1 ran out, display goes blank.
                        if (digit == 3'd1)
                        begin
                            state <= dotmatrix_pkg::CD_IDLE;
                        end
                    end
                    else
                    begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                default:
                begin
                    state <= dotmatrix_pkg::CD_IDLE;
                end
            endcase
        end
    end

    a_digit_range: assert property (@(posedge clk) disable iff (rst)
        digit <= dotmatrix_pkg::digit_t'(`DM_COUNT_START))
        else $error("countdown_ctrl: digit %0d above start value", digit);

    a_busy_digit: assert property (@(posedge clk) disable iff (rst)
        busy == (digit != '0))
        else $error("countdown_ctrl: busy %0b with digit %0d", busy, digit);

endmodule

// File: dotmatrix_pkg.sv
package dotmatrix_pkg;

    // Displayed digit, 0 is blank.
    typedef logic [2:0] digit_t;

    // Index of the row being scanned.
    typedef logic [2:0] row_idx_t;

    // Row select or column pattern, bit 7 is the leftmost column.
    typedef logic [7:0] row_bits_t;

    // Countdown FSM states.
    typedef enum logic
    {
        CD_IDLE,
        CD_COUNT
    } countdown_state_t;

endpackage

// File: dotmatrix_params.svh
`ifndef DOTMATRIX_PARAMS_SVH
`define DOTMATRIX_PARAMS_SVH

// First digit of the countdown.
// 3 and 4 also work, the colour follows the digit value.
`define DM_COUNT_START 5

// Clock cycles each digit stays on the display.
// Short value for simulation.
`define DM_HOLD_CYCLES 64

// Clock cycles spent on each scanned row.
`define DM_SCAN_CYCLES 4

`endif
